/* src/battle_pkg.sv */
// Battleship shared definitions
package battle_pkg;

    // ------------------------------------------------
    // Fleet rules
    // ------------------------------------------------
    localparam int NUM_SHIPS = 5;

    // Ship lengths in placement order
    localparam logic [2:0] SHIP_SIZE [NUM_SHIPS] = '{3'd5, 3'd4, 3'd3, 3'd3, 3'd2};

    // Cell word is {ship index, state}
    typedef enum logic [1:0] {
        CELL_EMPTY = 2'd0,
        CELL_SHIP  = 2'd1,
        CELL_MISS  = 2'd2,
        CELL_HIT   = 2'd3
    } cell_state_e;

    typedef enum logic [2:0] {
        RES_NONE     = 3'd0,
        RES_PLACED   = 3'd1,
        RES_REJECTED = 3'd2,
        RES_MISS     = 3'd3,
        RES_HIT      = 3'd4,
        RES_SUNK     = 3'd5
    } result_e;

    // ------------------------------------------------
    // Command word
    // ------------------------------------------------
    localparam logic [1:0] OP_PLACE = 2'b01;
    localparam logic [1:0] OP_FIRE  = 2'b10;

    typedef struct packed {
        logic [1:0]  opcode;
        logic        player;
        logic [19:0] rsvd;
        logic        across;
        logic [3:0]  row;
        logic [3:0]  col;
    } place_view_s;

    typedef struct packed {
        logic [1:0]  opcode;
        logic        player;
        logic [12:0] rsvd_hi;
        logic [3:0]  row;
        logic [3:0]  col;
        logic [7:0]  rsvd_lo;
    } fire_view_s;

    // Opcode and player sit in the same bits of both views
    typedef union packed {
        place_view_s place;
        fire_view_s  fire;
    } cmd_word_u;

    // Status word bit positions
    localparam int STATUS_RESULT  = 0;
    localparam int STATUS_OVER    = 4;
    localparam int STATUS_WINNER  = 5;
    localparam int STATUS_TURN    = 6;
    localparam int STATUS_PLACED0 = 8;
    localparam int STATUS_PLACED1 = 12;

endpackage

/* src/board_ram.sv */
`timescale 1ns/1ns
// Player board memory
module board_ram #(
    parameter int BOARD_SIZE = 10
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] row,
    input  logic [3:0] col,
    input  logic       rd_en,
    input  logic       wr_en,
    input  logic [4:0] wr_cell,
    output logic [4:0] rd_cell
);

    localparam int CELLS = BOARD_SIZE * BOARD_SIZE;
    localparam int AW    = $clog2(CELLS);

    logic [4:0]       mem [CELLS];
    logic [CELLS-1:0] valid;
    logic [AW-1:0]    addr;

    assign addr = AW'(row * BOARD_SIZE + col);

    // Valid flags make the whole board read EMPTY after reset
    always_ff @(posedge clk)
    begin
        if (reset)
            valid <= '0;
        else if (wr_en)
            valid[addr] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[addr] <= wr_cell;
        if (rd_en)
            rd_cell <= valid[addr] ? mem[addr] : 5'd0;
    end

    a_in_range: assert property (@(posedge clk) disable iff (reset)
        (rd_en || wr_en) |-> (row < BOARD_SIZE && col < BOARD_SIZE));

endmodule

/* src/fleet_table.sv */
`timescale 1ns/1ns
// Remaining ship cells per fleet
module fleet_table (
    input  logic       clk,
    input  logic       reset,
    input  logic       player,
    input  logic [2:0] ship,
    input  logic       load,
    input  logic       hit,
    output logic       ship_sunk,
    output logic       fleet_sunk
);

    logic [2:0] count [2][battle_pkg::NUM_SHIPS];
    logic [2:0] cur;
    logic       others_left;

    assign cur = count[player][ship];

    // Any other ship of this fleet still afloat
    always_comb
    begin
        others_left = 1'b0;
        for (int i = 0; i < battle_pkg::NUM_SHIPS; i++)
        begin
            if (i != int'(ship) && count[player][i] != 3'd0)
                others_left = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count      <= '{default: '0};
            ship_sunk  <= 1'b0;
            fleet_sunk <= 1'b0;
        end
        else if (load)
        begin
            count[player][ship] <= battle_pkg::SHIP_SIZE[ship];
        end
        else if (hit)
        begin
            count[player][ship] <= cur - 3'd1;
            ship_sunk           <= (cur == 3'd1);
            // Last cell of the last ship
            fleet_sunk          <= (cur == 3'd1) && !others_left;
        end
    end

    a_no_dead_hit: assert property (@(posedge clk) disable iff (reset)
        hit |-> cur != 3'd0);

endmodule

/* src/game_fsm.sv */
`timescale 1ns/1ns
// Battleship game controller
module game_fsm #(
    parameter int BOARD_SIZE = 10
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cmd_start,
    input  battle_pkg::cmd_word_u cmd_word,
    output logic                 cmd_done,
    output logic [31:0]          status,
    output logic                 game_over,
    output logic [3:0]           p0_row,
    output logic [3:0]           p0_col,
    output logic                 p0_rd_en,
    output logic                 p0_wr_en,
    output logic [4:0]           p0_wr_cell,
    input  logic [4:0]           p0_rd_cell,
    output logic [3:0]           p1_row,
    output logic [3:0]           p1_col,
    output logic                 p1_rd_en,
    output logic                 p1_wr_en,
    output logic [4:0]           p1_wr_cell,
    input  logic [4:0]           p1_rd_cell,
    output logic                 fl_player,
    output logic [2:0]           fl_ship,
    output logic                 fl_load,
    output logic                 fl_hit,
    input  logic                 ship_sunk,
    input  logic                 fleet_sunk
);

    localparam logic [2:0] IDLE         = 3'd0;
    localparam logic [2:0] DECODE       = 3'd1;
    localparam logic [2:0] PLACE_SCAN   = 3'd2;
    localparam logic [2:0] PLACE_WRITE  = 3'd3;
    localparam logic [2:0] SHOT_READ    = 3'd4;
    localparam logic [2:0] SHOT_RESOLVE = 3'd5;
    localparam logic [2:0] SUNK_WAIT    = 3'd6;
    localparam logic [2:0] REPORT       = 3'd7;

    logic [2:0]          state;
    battle_pkg::result_e result;
    logic                over;
    logic                winner;
    logic                turn;
    logic                shots_taken;
    logic [2:0]          placed [2];
    logic [3:0]          wrow;
    logic [3:0]          wcol;
    logic [2:0]          step;

    logic       player;
    logic       is_fire;
    logic       tgt;
    logic [2:0] ship_idx;
    logic [2:0] size;
    logic [4:0] rd_cell;
    logic [1:0] cell_st;
    logic       fits;
    logic       place_ok;
    logic       fire_ok;
    logic       last_write;
    logic       rd_go;
    logic       wr_go;
    logic [4:0] wr_data;

    // ------------------------------------------------
    // Command decode
    // ------------------------------------------------
    assign player   = cmd_word.place.player;
    assign is_fire  = (cmd_word.place.opcode == battle_pkg::OP_FIRE);
    // Shots go to the opponent board, placements to the own board
    assign tgt      = is_fire ? ~player : player;
    assign ship_idx = placed[player];
    assign size     = battle_pkg::SHIP_SIZE[ship_idx];
    assign rd_cell  = tgt ? p1_rd_cell : p0_rd_cell;
    assign cell_st  = rd_cell[1:0];

    always_comb
    begin
        if (cmd_word.place.across)
            fits = cmd_word.place.row < BOARD_SIZE
                && int'(cmd_word.place.col) + int'(size) <= BOARD_SIZE;
        else
            fits = cmd_word.place.col < BOARD_SIZE
                && int'(cmd_word.place.row) + int'(size) <= BOARD_SIZE;
    end

    assign place_ok = !shots_taken && placed[player] < battle_pkg::NUM_SHIPS && fits;
    assign fire_ok  = placed[0] == battle_pkg::NUM_SHIPS && placed[1] == battle_pkg::NUM_SHIPS
                   && player == turn && !over
                   && cmd_word.fire.row < BOARD_SIZE && cmd_word.fire.col < BOARD_SIZE;

    assign last_write = (state == PLACE_WRITE) && (step == size - 3'd1);

    // ------------------------------------------------
    // Board and fleet strobes
    // ------------------------------------------------
    assign rd_go = (state == PLACE_SCAN && step < size) || state == SHOT_READ;
    assign wr_go = state == PLACE_WRITE || (state == SHOT_RESOLVE
                && (cell_st == battle_pkg::CELL_EMPTY || cell_st == battle_pkg::CELL_SHIP));

    always_comb
    begin
        if (state == PLACE_WRITE)
            wr_data = {ship_idx, battle_pkg::CELL_SHIP};
        else if (cell_st == battle_pkg::CELL_SHIP)
            wr_data = {rd_cell[4:2], battle_pkg::CELL_HIT};
        else
            wr_data = {3'd0, battle_pkg::CELL_MISS};
    end

    assign p0_row     = wrow;
    assign p0_col     = wcol;
    assign p1_row     = wrow;
    assign p1_col     = wcol;
    assign p0_rd_en   = rd_go && !tgt;
    assign p1_rd_en   = rd_go && tgt;
    assign p0_wr_en   = wr_go && !tgt;
    assign p1_wr_en   = wr_go && tgt;
    assign p0_wr_cell = wr_data;
    assign p1_wr_cell = wr_data;

    assign fl_player = (state == SHOT_RESOLVE) ? ~player : player;
    assign fl_ship   = (state == SHOT_RESOLVE) ? rd_cell[4:2] : ship_idx;
    assign fl_load   = last_write;
    assign fl_hit    = (state == SHOT_RESOLVE) && (cell_st == battle_pkg::CELL_SHIP);
    assign cmd_done  = (state == REPORT);
    assign game_over = over;

    always_comb
    begin
        status = '0;
        status[battle_pkg::STATUS_RESULT +: 3]  = result;
        status[battle_pkg::STATUS_OVER]         = over;
        status[battle_pkg::STATUS_WINNER]       = winner;
        status[battle_pkg::STATUS_TURN]         = turn;
        status[battle_pkg::STATUS_PLACED0 +: 3] = placed[0];
        status[battle_pkg::STATUS_PLACED1 +: 3] = placed[1];
    end

    // Walk position, restarted at the origin for the write pass
    always_ff @(posedge clk)
    begin
        if (state == DECODE || (state == PLACE_SCAN && step == size))
        begin
            step <= 3'd0;
            wrow <= is_fire ? cmd_word.fire.row : cmd_word.place.row;
            wcol <= is_fire ? cmd_word.fire.col : cmd_word.place.col;
        end
        else if (state == PLACE_SCAN || state == PLACE_WRITE)
        begin
            step <= step + 3'd1;
            if (cmd_word.place.across)
                wcol <= wcol + 4'd1;
            else
                wrow <= wrow + 4'd1;
        end
    end

    // ------------------------------------------------
    // Game state
    // ------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= IDLE;
            result      <= battle_pkg::RES_NONE;
            over        <= 1'b0;
            winner      <= 1'b0;
            turn        <= 1'b0;
            shots_taken <= 1'b0;
            placed      <= '{default: '0};
        end
        else
        begin
            case (state)
                IDLE:
                    if (cmd_start)
                        state <= DECODE;
                DECODE:
                    if (cmd_word.place.opcode == battle_pkg::OP_PLACE && place_ok)
                        state <= PLACE_SCAN;
                    else if (is_fire && fire_ok)
                        state <= SHOT_READ;
                    else
                    begin
                        result <= battle_pkg::RES_REJECTED;
                        state  <= REPORT;
                    end
                PLACE_SCAN:
                    // Data of the read issued one step earlier
                    if (step != 3'd0 && cell_st != battle_pkg::CELL_EMPTY)
                    begin
                        result <= battle_pkg::RES_REJECTED;
                        state  <= REPORT;
                    end
                    else if (step == size)
                        state <= PLACE_WRITE;
                PLACE_WRITE:
                    if (last_write)
                    begin
                        placed[player] <= placed[player] + 3'd1;
                        result         <= battle_pkg::RES_PLACED;
                        state          <= REPORT;
                    end
                SHOT_READ:
                    state <= SHOT_RESOLVE;
                SHOT_RESOLVE:
                    if (wr_go)
                    begin
                        turn        <= ~turn;
                        shots_taken <= 1'b1;
                        result      <= battle_pkg::RES_MISS;
                        state       <= (cell_st == battle_pkg::CELL_SHIP) ? SUNK_WAIT : REPORT;
                    end
                    else
                    begin
                        result <= battle_pkg::RES_REJECTED;
                        state  <= REPORT;
                    end
                SUNK_WAIT:
                begin
                    result <= ship_sunk ? battle_pkg::RES_SUNK : battle_pkg::RES_HIT;
                    if (fleet_sunk)
                    begin
                        over   <= 1'b1;
                        winner <= player;
                    end
                    state <= REPORT;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    a_one_board: assert property (@(posedge clk) disable iff (reset)
        !(p0_wr_en && p1_wr_en));
    a_done_exit: assert property (@(posedge clk) disable iff (reset)
        cmd_done |=> (state == IDLE && !cmd_done));

endmodule

/* src/wb_cmd_port.sv */
`timescale 1ns/1ns
// Wishbone command and status port
module wb_cmd_port (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic                  wb_adr,
    input  logic [31:0]           wb_dat_w,
    output logic [31:0]           wb_dat_r,
    output logic                  wb_ack,
    output logic                  cmd_start,
    output battle_pkg::cmd_word_u cmd_word,
    input  logic                  cmd_done,
    input  logic [31:0]           status
);

    logic bus_req;
    logic cmd_sel;
    logic busy;
    // Command of this bus cycle already launched
    logic launched;

    assign bus_req = wb_cyc && wb_stb;
    assign cmd_sel = bus_req && wb_we && !wb_adr;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb_ack    <= 1'b0;
            cmd_start <= 1'b0;
            busy      <= 1'b0;
            launched  <= 1'b0;
        end
        else
        begin
            cmd_start <= 1'b0;
            wb_ack    <= 1'b0;
            if (!wb_stb)
                launched <= 1'b0;
            if (cmd_sel && !launched)
            begin
                cmd_start <= 1'b1;
                busy      <= 1'b1;
                launched  <= 1'b1;
            end
            if (cmd_done)
            begin
                busy   <= 1'b0;
                wb_ack <= 1'b1;
            end
            else if (bus_req && !cmd_sel && !wb_ack)
                wb_ack <= 1'b1;
        end
    end

    // Only a status read returns data, all else reads zero
    always_ff @(posedge clk)
    begin
        if (cmd_sel && !launched)
            cmd_word <= wb_dat_w;
        wb_dat_r <= (bus_req && !wb_we && wb_adr) ? status : 32'd0;
    end

    a_done_busy: assert property (@(posedge clk) disable iff (reset)
        cmd_done |-> busy);
    a_ack_pulse: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack);

endmodule

/* src/battle_top.sv */
`timescale 1ns/1ns
// Battleship engine top level
module battle_top #(
    parameter int BOARD_SIZE = 10
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic        wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        game_over
);

    logic                  cmd_start;
    logic                  cmd_done;
    battle_pkg::cmd_word_u cmd_word;
    logic [31:0]           status;
    logic [3:0]            p0_row, p0_col, p1_row, p1_col;
    logic                  p0_rd_en, p0_wr_en, p1_rd_en, p1_wr_en;
    logic [4:0]            p0_wr_cell, p0_rd_cell, p1_wr_cell, p1_rd_cell;
    logic                  fl_player, fl_load, fl_hit;
    logic [2:0]            fl_ship;
    logic                  ship_sunk, fleet_sunk;

    wb_cmd_port wb_cmd_port_i (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .cmd_start(cmd_start), .cmd_word(cmd_word), .cmd_done(cmd_done),
        .status(status)
    );

    game_fsm #(.BOARD_SIZE(BOARD_SIZE)) game_fsm_i (
        .clk(clk), .reset(reset),
        .cmd_start(cmd_start), .cmd_word(cmd_word), .cmd_done(cmd_done),
        .status(status), .game_over(game_over),
        .p0_row(p0_row), .p0_col(p0_col), .p0_rd_en(p0_rd_en), .p0_wr_en(p0_wr_en),
        .p0_wr_cell(p0_wr_cell), .p0_rd_cell(p0_rd_cell),
        .p1_row(p1_row), .p1_col(p1_col), .p1_rd_en(p1_rd_en), .p1_wr_en(p1_wr_en),
        .p1_wr_cell(p1_wr_cell), .p1_rd_cell(p1_rd_cell),
        .fl_player(fl_player), .fl_ship(fl_ship), .fl_load(fl_load), .fl_hit(fl_hit),
        .ship_sunk(ship_sunk), .fleet_sunk(fleet_sunk)
    );

    board_ram #(.BOARD_SIZE(BOARD_SIZE)) board_p0 (
        .clk(clk), .reset(reset), .row(p0_row), .col(p0_col),
        .rd_en(p0_rd_en), .wr_en(p0_wr_en), .wr_cell(p0_wr_cell), .rd_cell(p0_rd_cell)
    );

    board_ram #(.BOARD_SIZE(BOARD_SIZE)) board_p1 (
        .clk(clk), .reset(reset), .row(p1_row), .col(p1_col),
        .rd_en(p1_rd_en), .wr_en(p1_wr_en), .wr_cell(p1_wr_cell), .rd_cell(p1_rd_cell)
    );

    fleet_table fleet_table_i (
        .clk(clk), .reset(reset), .player(fl_player), .ship(fl_ship),
        .load(fl_load), .hit(fl_hit), .ship_sunk(ship_sunk), .fleet_sunk(fleet_sunk)
    );

endmodule

/* include/tb_tasks.svh */
// Testbench bus tasks and game model
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

localparam int TB_BOARD = 10;

logic [31:0]         lfsr = 32'h7601;
logic [4:0]          m_cell [2][TB_BOARD][TB_BOARD];
int                  m_left [2][battle_pkg::NUM_SHIPS];
int                  m_placed [2];
logic                m_turn;
logic                m_over;
logic                m_winner;
logic                m_started;
battle_pkg::result_e m_result;

// One Wishbone classic access, inputs change at the rising edge
task automatic bus_cycle(input logic we, input logic adr, input logic [31:0] wdata,
                         output logic [31:0] rdata);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    do @(posedge clk); while (wb_ack !== 1'b1);
    rdata = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
endtask

task automatic bus_write(input logic adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, data, unused);
endtask

task automatic bus_read(input logic adr, output logic [31:0] data);
    bus_cycle(1'b0, adr, 32'd0, data);
endtask

// Galois LFSR, one step per bit taken
function automatic logic [7:0] lfsr_take(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
        v    = {v[6:0], lfsr[0]};
    end
    return v;
endfunction

function automatic void ref_reset();
    m_cell    = '{default: '0};
    m_left    = '{default: 0};
    m_placed  = '{default: 0};
    m_turn    = 1'b0;
    m_over    = 1'b0;
    m_winner  = 1'b0;
    m_started = 1'b0;
    m_result  = battle_pkg::RES_NONE;
endfunction

function automatic logic [31:0] ref_status();
    logic [31:0] st;
    st = '0;
    st[battle_pkg::STATUS_RESULT +: 3]  = m_result;
    st[battle_pkg::STATUS_OVER]         = m_over;
    st[battle_pkg::STATUS_WINNER]       = m_winner;
    st[battle_pkg::STATUS_TURN]         = m_turn;
    st[battle_pkg::STATUS_PLACED0 +: 3] = 3'(m_placed[0]);
    st[battle_pkg::STATUS_PLACED1 +: 3] = 3'(m_placed[1]);
    return st;
endfunction

// Apply one command to the model, return the expected status
function automatic logic [31:0] ref_apply(input battle_pkg::cmd_word_u w);
    int   pl;
    int   r;
    int   c;
    int   sz;
    int   sh;
    int   dr;
    int   dc;
    logic ok;
    pl = w.place.player;
    m_result = battle_pkg::RES_REJECTED;
    if (w.place.opcode == battle_pkg::OP_PLACE && !m_started
        && m_placed[pl] < battle_pkg::NUM_SHIPS)
    begin
        r  = w.place.row;
        c  = w.place.col;
        sh = m_placed[pl];
        sz = battle_pkg::SHIP_SIZE[sh];
        dr = w.place.across ? 0 : 1;
        dc = w.place.across ? 1 : 0;
        ok = (r + dr * (sz - 1) < TB_BOARD) && (c + dc * (sz - 1) < TB_BOARD);
        for (int i = 0; i < sz && ok; i++)
            if (m_cell[pl][r + dr * i][c + dc * i][1:0] != battle_pkg::CELL_EMPTY)
                ok = 1'b0;
        if (ok)
        begin
            for (int i = 0; i < sz; i++)
                m_cell[pl][r + dr * i][c + dc * i] = {3'(sh), battle_pkg::CELL_SHIP};
            m_left[pl][sh] = sz;
            m_placed[pl]++;
            m_result = battle_pkg::RES_PLACED;
        end
    end
    else if (w.fire.opcode == battle_pkg::OP_FIRE && m_placed[0] == 5 && m_placed[1] == 5
             && pl == m_turn && !m_over && w.fire.row < TB_BOARD && w.fire.col < TB_BOARD)
    begin
        r = w.fire.row;
        c = w.fire.col;
        if (m_cell[1 - pl][r][c][1:0] == battle_pkg::CELL_EMPTY)
        begin
            m_cell[1 - pl][r][c] = {3'd0, battle_pkg::CELL_MISS};
            m_result = battle_pkg::RES_MISS;
        end
        else if (m_cell[1 - pl][r][c][1:0] == battle_pkg::CELL_SHIP)
        begin
            sh = m_cell[1 - pl][r][c][4:2];
            m_cell[1 - pl][r][c][1:0] = battle_pkg::CELL_HIT;
            m_left[1 - pl][sh]--;
            m_result = (m_left[1 - pl][sh] == 0) ? battle_pkg::RES_SUNK : battle_pkg::RES_HIT;
            if (m_left[1 - pl].sum() == 0)
            begin
                m_over   = 1'b1;
                m_winner = pl[0];
            end
        end
        if (m_result != battle_pkg::RES_REJECTED)
        begin
            m_started = 1'b1;
            m_turn    = ~m_turn;
        end
    end
    return ref_status();
endfunction

`endif

/* bench/tb_battle.sv */
`timescale 1ns/1ns
// Battleship engine testbench
module tb_battle;

    localparam int BOARD_SIZE    = 10;
    localparam int CLK_NS        = 10;
    // Upper bound on bus accesses, each command is followed by a status read
    localparam int MAX_ACCESSES  = 320;
    localparam int ACCESS_CYCLES = 25;

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic        wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        game_over;

    int          cycles   = 0;
    int          errors   = 0;
    int          checks   = 0;
    int          issued   = 0;
    int          compared = 0;

    // Status words waiting for the compare process
    logic [31:0] exp_q [$];
    logic [31:0] got_q [$];
    logic        over_q [$];
    string       tag_q [$];

    `include "tb_tasks.svh"

    battle_top #(.BOARD_SIZE(BOARD_SIZE)) battle_top_i (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .game_over(game_over)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always @(posedge clk)
        cycles <= cycles + 1;

    // ------------------------------------------------
    // Command words
    // ------------------------------------------------
    function automatic battle_pkg::cmd_word_u make_place(input logic pl, input logic across,
                                                         input int row, input int col);
        battle_pkg::cmd_word_u w;
        w              = '0;
        w.place.opcode = battle_pkg::OP_PLACE;
        w.place.player = pl;
        w.place.across = across;
        w.place.row    = 4'(row);
        w.place.col    = 4'(col);
        return w;
    endfunction

    function automatic battle_pkg::cmd_word_u make_fire(input logic pl, input int row,
                                                        input int col);
        battle_pkg::cmd_word_u w;
        w             = '0;
        w.fire.opcode = battle_pkg::OP_FIRE;
        w.fire.player = pl;
        w.fire.row    = 4'(row);
        w.fire.col    = 4'(col);
        return w;
    endfunction

    // Status read, ack one cycle after stb
    task automatic check_status(input string tag);
        int          t0;
        logic [31:0] got_word;
        t0 = cycles;
        bus_read(1'b1, got_word);
        if (cycles - t0 != 3)
        begin
            errors++;
            $display("FAIL %0t: %s status ack after %0d cycles", $time, tag, cycles - t0);
        end
        exp_q.push_back(ref_status());
        got_q.push_back(got_word);
        over_q.push_back(game_over);
        tag_q.push_back(tag);
        issued++;
    endtask

    // Want below zero leaves the result to the model alone
    task automatic run_cmd(input battle_pkg::cmd_word_u w, input int want, input string tag);
        int          t0;
        logic [31:0] exp_word;
        t0 = cycles;
        bus_write(1'b0, w);
        if (cycles - t0 > 22)
        begin
            errors++;
            $display("FAIL %0t: %s command ack after %0d cycles", $time, tag, cycles - t0);
        end
        exp_word = ref_apply(w);
        if (want >= 0 && int'(exp_word[2:0]) != want)
        begin
            errors++;
            $display("FAIL %0t: %s model result %0d, scenario needs %0d",
                     $time, tag, exp_word[2:0], want);
        end
        check_status(tag);
    endtask

    // Player 1 passes the turn back with a shot into open water
    task automatic p1_miss_shot();
        for (int r = 0; r < BOARD_SIZE; r++)
            for (int c = 0; c < BOARD_SIZE; c++)
                if (m_cell[0][r][c][1:0] == battle_pkg::CELL_EMPTY)
                begin
                    run_cmd(make_fire(1'b1, r, c), int'(battle_pkg::RES_MISS), "filler shot");
                    return;
                end
    endtask

    // ------------------------------------------------
    // Compare process
    // ------------------------------------------------
    initial
    begin
        logic [31:0] e;
        logic [31:0] g;
        logic        o;
        string       t;
        forever
        begin
            wait (issued > compared);
            e = exp_q.pop_front();
            g = got_q.pop_front();
            o = over_q.pop_front();
            t = tag_q.pop_front();
            checks++;
            if (g !== e)
            begin
                errors++;
                $display("FAIL %0t: %s status %h, expected %h", $time, t, g, e);
            end
            if (o !== e[battle_pkg::STATUS_OVER])
            begin
                errors++;
                $display("FAIL %0t: %s game_over %b, expected %b", $time, t, o,
                         e[battle_pkg::STATUS_OVER]);
            end
            compared++;
        end
    end

    // ------------------------------------------------
    // Test sequence
    // ------------------------------------------------
    initial
    begin
        int          r;
        int          c;
        int          want;
        logic [31:0] got_word;
        clk      = 1'b0;
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 1'b0;
        wb_dat_w = 32'd0;
        ref_reset();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        check_status("after reset");

        bus_write(1'b1, 32'hFFFF_FFFF);
        check_status("write to status");

        // Off the board in each direction
        run_cmd(make_place(1'b0, 1'b1, 0, 6), int'(battle_pkg::RES_REJECTED), "off right");
        run_cmd(make_place(1'b0, 1'b0, 6, 0), int'(battle_pkg::RES_REJECTED), "off bottom");
        run_cmd(make_place(1'b0, 1'b1, 10, 0), int'(battle_pkg::RES_REJECTED), "row out");
        run_cmd(make_place(1'b0, 1'b0, 0, 12), int'(battle_pkg::RES_REJECTED), "col out");

        run_cmd(make_place(1'b0, 1'b1, 0, 0), int'(battle_pkg::RES_PLACED), "p0 ship 0");

        // Status is nonzero now, so a read of address 0 must not return it
        bus_read(1'b0, got_word);
        if (got_word !== 32'd0)
        begin
            errors++;
            $display("FAIL %0t: read of address 0 gave %h", $time, got_word);
        end

        run_cmd(make_fire(1'b0, 0, 0), int'(battle_pkg::RES_REJECTED), "early shot");
        run_cmd(make_place(1'b0, 1'b0, 0, 3), int'(battle_pkg::RES_REJECTED), "overlap first");
        run_cmd(make_place(1'b0, 1'b0, 2, 2), int'(battle_pkg::RES_PLACED), "p0 ship 1");
        // Collides on its last cell only
        run_cmd(make_place(1'b0, 1'b1, 3, 0), int'(battle_pkg::RES_REJECTED), "overlap last");
        run_cmd(make_place(1'b0, 1'b1, 7, 0), int'(battle_pkg::RES_PLACED), "p0 ship 2");
        run_cmd(make_place(1'b0, 1'b0, 4, 6), int'(battle_pkg::RES_PLACED), "p0 ship 3");
        run_cmd(make_place(1'b0, 1'b1, 8, 7), int'(battle_pkg::RES_PLACED), "p0 ship 4");
        run_cmd(make_place(1'b0, 1'b1, 9, 0), int'(battle_pkg::RES_REJECTED), "sixth ship");

        run_cmd(make_place(1'b1, 1'b0, 0, 9), int'(battle_pkg::RES_PLACED), "p1 ship 0");
        run_cmd(make_place(1'b1, 1'b1, 9, 0), int'(battle_pkg::RES_PLACED), "p1 ship 1");
        run_cmd(make_place(1'b1, 1'b0, 5, 5), int'(battle_pkg::RES_PLACED), "p1 ship 2");
        run_cmd(make_place(1'b1, 1'b1, 1, 1), int'(battle_pkg::RES_PLACED), "p1 ship 3");
        run_cmd(make_place(1'b1, 1'b0, 3, 0), int'(battle_pkg::RES_PLACED), "p1 ship 4");

        // Turn, bounds and repeat rules
        run_cmd(make_fire(1'b1, 0, 0), int'(battle_pkg::RES_REJECTED), "wrong turn");
        run_cmd(make_fire(1'b0, 10, 3), int'(battle_pkg::RES_REJECTED), "off-board shot");
        run_cmd(make_fire(1'b0, 0, 0), int'(battle_pkg::RES_MISS), "p0 first shot");
        run_cmd(make_fire(1'b1, 9, 9), int'(battle_pkg::RES_MISS), "p1 first shot");
        run_cmd(make_fire(1'b0, 0, 0), int'(battle_pkg::RES_REJECTED), "repeat shot");
        run_cmd(make_place(1'b1, 1'b1, 6, 0), int'(battle_pkg::RES_REJECTED), "late place");

        // Alternating shots at pseudo-random cells
        for (int i = 0; i < 40; i++)
        begin
            r = lfsr_take(4);
            c = lfsr_take(4);
            run_cmd(make_fire(m_turn, r, c), -1, "random shot");
        end

        // Player 0 sweeps every ship cell left on player 1's board
        for (int rr = 0; rr < BOARD_SIZE; rr++)
            for (int cc = 0; cc < BOARD_SIZE; cc++)
                if (m_cell[1][rr][cc][1:0] == battle_pkg::CELL_SHIP)
                begin
                    if (m_turn)
                        p1_miss_shot();
                    want = (m_left[1].sum() == 1) ? int'(battle_pkg::RES_SUNK) : -1;
                    run_cmd(make_fire(1'b0, rr, cc), want, "sweep shot");
                end
        if (!(m_over && m_winner == 1'b0))
        begin
            errors++;
            $display("The sweep did not end the game with player 0 as winner");
        end

        run_cmd(make_fire(1'b1, 9, 8), int'(battle_pkg::RES_REJECTED), "shot after end");
        run_cmd(make_fire(1'b0, 9, 7), int'(battle_pkg::RES_REJECTED), "p0 after end");
        run_cmd(make_place(1'b0, 1'b1, 5, 5), int'(battle_pkg::RES_REJECTED), "place after end");

        wait (compared == issued);
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // Watchdog sized from the access count
    initial
    begin
        #(MAX_ACCESSES * ACCESS_CYCLES * CLK_NS + 1000);
        $display("Timeout: the test sequence did not finish in time");
        $display("Done: errors found");
        $finish;
    end

endmodule

/* all.f */
+incdir+include
src/battle_pkg.sv
src/board_ram.sv
src/fleet_table.sv
src/game_fsm.sv
src/wb_cmd_port.sv
src/battle_top.sv
bench/tb_battle.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the Battleship testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_battle -o sim_battle

./obj_dir/sim_battle | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
